//--- src.f
+incdir+hw
hw/branchPkg.sv
hw/cla16.sv
hw/instrIntake.sv
hw/pcControl.sv
hw/pcOutQueue.sv
hw/branchTop.sv
testbench/tbClock.sv
testbench/branchTb.sv

//--- Makefile
# Verilator simulation of the next-address unit

VERILATOR ?= verilator
TOP       ?= branchTb
FLAGS     ?= --binary --timing --assert -Wno-fatal
BUILD     ?= obj_dir
FILELIST  ?= src.f
PASS_MSG  := TEST RESULT: PASS

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- testbench/branchTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branchTb;

  import branchPkg::*;

  logic        clk;
  logic        rstN;
  logic        instrValid;
  logic        instrReady;
  instrWord    instr;
  logic [3:0]  rsIdx;
  logic [15:0] rsData;
  logic        flagsWe;
  logic [2:0]  flagsIn;
  logic        pcValid;
  logic        pcReady;
  logic [15:0] nextPc;

  logic [15:0] refPc;          // Model PC after the last accepted word
  logic [2:0]  refFlags;       // Flags the DUT holds, Z V N
  logic [15:0] expQ[$];        // Expected nextPc values in order
  logic [15:0] lastWord;       // Most recent accepted word
  bit          sawStall;       // instrReady seen low under back-pressure
  bit          randReady;      // Random pcReady gaps enabled
  logic [31:0] stimSeed;
  logic [31:0] readySeed;

  tbClock #(.PERIOD_NS(40)) uClock (.clk(clk));

  branchTop DUT (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .rsIdx      (rsIdx),
    .rsData     (rsData),
    .flagsWe    (flagsWe),
    .flagsIn    (flagsIn),
    .pcValid    (pcValid),
    .pcReady    (pcReady),
    .nextPc     (nextPc)
  );

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Register file stand-in, index 0 lands near the top, index F near zero
  function automatic logic [15:0] regModel(input logic [3:0] idx);
    return {~idx, ~idx, ~idx, idx[3:1], 1'b0};
  endfunction

  function automatic bit condHolds(input logic [2:0] cond, input logic [2:0] fl);
    bit z;
    bit v;
    bit n;
    z = fl[2];
    v = fl[1];
    n = fl[0];
    case (cond)
      3'd0:    return !z;             // NE
      3'd1:    return z;              // EQ
      3'd2:    return !z && !n;       // GT
      3'd3:    return n;              // LT
      3'd4:    return z || !n;        // GE
      3'd5:    return z || n;         // LE
      3'd6:    return v;              // OV
      default: return 1'b1;           // AL
    endcase
  endfunction

  // Reference next PC for one word
  function automatic logic [15:0] expectNext(input logic [15:0] word, input logic [15:0] pc,
                                             input logic [2:0] fl);
    logic [15:0]        seq;
    logic signed [15:0] disp;
    seq  = pc + 16'd2;
    disp = $signed(word[8:0]);  // Word offset, sign extended
    if (word[15:12] == `OPC_B && condHolds(word[11:9], fl)) begin
      return seq + disp + disp;
    end else if (word[15:12] == `OPC_BR && condHolds(word[11:9], fl)) begin
      return regModel(word[7:4]);
    end
    return seq;
  endfunction

  function automatic logic [15:0] bWord(input logic [2:0] cond, input logic [8:0] off);
    return {`OPC_B, cond, off};
  endfunction

  function automatic logic [15:0] brWord(input logic [2:0] cond, input logic [3:0] idx);
    return {`OPC_BR, cond, 1'b0, idx, 4'h0};
  endfunction

  // Any opcode but the two branches
  function automatic logic [15:0] otherWord(input logic [31:0] r);
    logic [3:0] op;
    op = r[19:16];
    if (op == `OPC_B || op == `OPC_BR) begin
      op = op ^ 4'h4;
    end
    return {op, r[31:20]};
  endfunction

  task automatic failStop(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic valueFail(input string name, input logic [15:0] expVal,
                           input logic [15:0] actVal);
    failStop($sformatf("[FAIL] t=%0t %s expected %h actual %h", $time, name, expVal, actVal));
  endtask

  ////////////////////
  // Register read and pcReady
  ////////////////////
  assign rsData = regModel(rsIdx);  // Same-cycle read

  always @(posedge clk) begin
    if (randReady) begin
      readySeed = xorshift32(readySeed);
      pcReady <= (readySeed[2:0] > 3'd4);  // Mostly stalled, fills the queue
    end else begin
      pcReady <= 1'b1;
    end
  end

  ////////////////////
  // Model and checks
  ////////////////////
  always @(posedge clk) begin : model
    logic [15:0] word;
    if (rstN) begin
      // Index field of the held word goes out on rsIdx
      if (DUT.heldValid) begin
        assert (rsIdx === lastWord[7:4])
          else valueFail("rsIdx", {12'h000, lastWord[7:4]}, {12'h000, rsIdx});
      end
      if (pcValid && pcReady) begin
        if (expQ.size() == 0) begin
          failStop("nextPc was delivered with no instruction outstanding");
        end else begin
          assert (nextPc === expQ[0]) else valueFail("nextPc", expQ[0], nextPc);
          void'(expQ.pop_front());
        end
      end
      if (instrValid && instrReady) begin
        word  = instr;
        refPc = expectNext(word, refPc, refFlags);
        expQ.push_back(refPc);
        lastWord = word;
      end
      if (randReady && !instrReady) sawStall = 1'b1;
    end
  end

  ////////////////////
  // Stimulus tasks
  ////////////////////
  // Present a word and wait for its transfer edge
  task automatic issue(input logic [15:0] word);
    int waited;
    waited = 0;
    instrValid <= 1'b1;
    instr      <= word;
    @(posedge clk);
    while (!instrReady && waited < 100) begin
      waited++;
      @(posedge clk);
    end
    if (!instrReady) failStop("Timeout: instrReady stayed low for 100 cycles");
  endtask

  task automatic idle();
    instrValid <= 1'b0;
    @(posedge clk);
  endtask

  // Wait until nothing is in flight
  task automatic drain();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    instrValid <= 1'b0;
    while (quiet < 4 && waited < 200) begin
      @(posedge clk);
      waited++;
      if (!pcValid && expQ.size() == 0) quiet++;
      else quiet = 0;
    end
    if (quiet < 4) failStop("Timeout: the next-PC stream did not drain");
  endtask

  task automatic setFlags(input logic [2:0] f);
    drain();
    flagsWe <= 1'b1;
    flagsIn <= f;
    @(posedge clk);
    flagsWe  <= 1'b0;
    refFlags = f;  // Written on this edge
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin : stimulus
    int          i;
    int          f;
    int          c;
    int          round;
    logic [31:0] r;
    logic [15:0] word;
    rstN       <= 1'b0;
    instrValid <= 1'b0;
    instr      <= '0;
    flagsWe    <= 1'b0;
    flagsIn    <= 3'b000;
    pcReady    <= 1'b1;
    refPc     = `PC_RESET_ADDR;
    refFlags  = 3'b000;
    lastWord  = '0;
    sawStall  = 1'b0;
    randReady = 1'b0;
    stimSeed  = 32'd58;
    readySeed = 32'd58 ^ 32'hA5A5_0000;

    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    assert (!pcValid) else failStop("pcValid is high right after reset");
    assert (instrReady) else failStop("instrReady is low right after reset");

    // Straight-line code, PC climbs by 2
    for (i = 0; i < 8; i++) begin
      stimSeed = xorshift32(stimSeed);
      issue(otherWord(stimSeed));
    end

    // Every condition under every flag value
    for (f = 0; f < 8; f++) begin
      setFlags(3'(f));
      for (c = 0; c < 8; c++) begin
        stimSeed = xorshift32(stimSeed);
        issue(bWord(3'(c), stimSeed[8:0]));
        issue(brWord(3'(c), stimSeed[12:9]));
      end
    end

    // Offsets at both ends and 16-bit wrap
    issue(brWord(3'd7, 4'hF));   // To 000E
    issue(bWord(3'd7, 9'h1FF));  // Back one word
    issue(bWord(3'd7, 9'h100));  // Below zero
    issue(brWord(3'd7, 4'h0));   // To FFF0
    issue(bWord(3'd7, 9'h0FF));  // Past the top
    issue(bWord(3'd7, 9'h080));
    issue(bWord(3'd7, 9'h000));
    issue(bWord(3'd7, 9'h1C0));

    // BR taken and not taken with Z set
    setFlags(3'b100);
    issue(brWord(3'd1, 4'h3));
    issue(brWord(3'd0, 4'h5));
    issue(brWord(3'd3, 4'hA));
    issue(brWord(3'd4, 4'h6));

    // Random mix under back-pressure
    for (round = 0; round < 4; round++) begin
      stimSeed = xorshift32(stimSeed);
      setFlags(stimSeed[2:0]);
      randReady = 1'b1;
      for (i = 0; i < 40; i++) begin
        stimSeed = xorshift32(stimSeed);
        r = stimSeed;
        case (r[1:0])
          2'd0:    word = {`OPC_B, r[13:2]};
          2'd1:    word = {`OPC_BR, r[13:2]};  // Pad bits random too
          default: word = otherWord(r);
        endcase
        if (r[20:18] == 3'd0) idle();  // Occasional gap on the input
        issue(word);
      end
      randReady = 1'b0;
    end

    drain();
    assert (sawStall) else failStop("instrReady never fell under back-pressure");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench
module tbClock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  ////////////////////
  // Clock
  ////////////////////
  initial begin
    clk = 1'b0;  // Start low, first rising edge at half period
  end

  always #(PERIOD_NS / 2) clk = ~clk;  // 50% duty

endmodule

`default_nettype wire

//--- hw/branchTop.sv
`timescale 1ns/1ps
`default_nettype none

module branchTop (
  input  wire                     clk,
  input  wire                     rstN,
  // Instruction stream
  input  wire                     instrValid,
  output logic                    instrReady,
  input  var branchPkg::instrWord instr,
  // Register file read port
  output logic [3:0]              rsIdx,
  input  wire [15:0]              rsData,
  // Flags from the ALU
  input  wire                     flagsWe,
  input  wire [2:0]               flagsIn,
  // Next-PC stream
  output logic                    pcValid,
  input  wire                     pcReady,
  output logic [15:0]             nextPc
);

  import branchPkg::*;

  ////////////////////
  // Internal nets
  ////////////////////
  logic        heldValid;
  logic        heldReady;
  opcode       heldOp;
  condCode     heldCond;
  logic [8:0]  heldOffset;
  logic        pushValid;
  logic        pushReady;
  logic [15:0] pushPc;

  instrIntake uIntake (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .heldValid  (heldValid),
    .heldReady  (heldReady),
    .heldOp     (heldOp),
    .heldCond   (heldCond),
    .heldOffset (heldOffset),
    .heldRsIdx  (rsIdx)       // Register read goes out directly
  );

  pcControl uControl (
    .clk        (clk),
    .rstN       (rstN),
    .heldValid  (heldValid),
    .heldReady  (heldReady),
    .heldOp     (heldOp),
    .heldCond   (heldCond),
    .heldOffset (heldOffset),
    .rsData     (rsData),
    .flagsWe    (flagsWe),
    .flagsIn    (flagsIn),
    .pushValid  (pushValid),
    .pushReady  (pushReady),
    .pushPc     (pushPc)
  );

  pcOutQueue uQueue (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushPc    (pushPc),
    .pcValid   (pcValid),
    .pcReady   (pcReady),
    .nextPc    (nextPc)
  );

endmodule

`default_nettype wire

//--- hw/pcOutQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module pcOutQueue #(
  parameter int DEPTH = `QUEUE_DEPTH
) (
  input  wire         clk,
  input  wire         rstN,
  // Push side
  input  wire         pushValid,
  output logic        pushReady,
  input  wire [15:0]  pushPc,
  // Pop side
  output logic        pcValid,
  input  wire         pcReady,
  output logic [15:0] nextPc
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [15:0]      mem [DEPTH];  // Entry storage, no reset
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;        // Entries held
  logic             doPush;
  logic             doPop;

  assign pushReady = (count != CNT_W'(DEPTH));  // Low when full
  assign pcValid   = (count != '0);
  assign doPush    = pushValid & pushReady;
  assign doPop     = pcValid & pcReady;

  // Head entry straight from the storage flops
  assign nextPc = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushPc;
    end
  end

  ////////////////////
  // Pointers, count
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/pcControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module pcControl (
  input  wire                     clk,
  input  wire                     rstN,
  // Held instruction from intake
  input  wire                     heldValid,
  output logic                    heldReady,
  input  var branchPkg::opcode    heldOp,
  input  var branchPkg::condCode  heldCond,
  input  wire [8:0]               heldOffset,
  // Register read result for BR
  input  wire [15:0]              rsData,
  // Flag write from the ALU
  input  wire                     flagsWe,
  input  wire [2:0]               flagsIn,
  // Push side of the output queue
  output logic                    pushValid,
  input  wire                     pushReady,
  output logic [15:0]             pushPc
);

  import branchPkg::*;

  logic [15:0] pc;            // Current PC
  logic [2:0]  flags;         // Z, V, N
  logic        flagZ;
  logic        flagV;
  logic        flagN;
  logic [15:0] pcPlus2;       // Fall-through address
  logic [15:0] offsetExt;     // Byte offset, sign extended
  logic [15:0] branchTarget;  // PC+2 plus offset
  logic [15:0] targetPc;      // Selected next PC
  logic        condMet;
  logic        isBranch;
  logic        takeBranch;
  logic        consume;       // Held word retires this edge

  ////////////////////
  // Adders
  ////////////////////
  cla16 uAddNext (
    .a   (pc),
    .b   (16'h0002),
    .sum (pcPlus2)
  );

  // Word offset to byte offset
  assign offsetExt = {{6{heldOffset[8]}}, heldOffset, 1'b0};

  cla16 uAddBranch (
    .a   (pcPlus2),
    .b   (offsetExt),
    .sum (branchTarget)
  );

  ////////////////////
  // Condition check
  ////////////////////
  assign flagZ = flags[2];
  assign flagV = flags[1];
  assign flagN = flags[0];

  always_comb begin
    condMet = 1'b0;
    case (heldCond)
      condNe: condMet = ~flagZ;
      condEq: condMet = flagZ;
      condGt: condMet = ~flagZ & ~flagN;
      condLt: condMet = flagN;
      condGe: condMet = flagZ | (~flagZ & ~flagN);
      condLe: condMet = flagZ | flagN;
      condOv: condMet = flagV;
      condAl: condMet = 1'b1;
      default: condMet = 1'b0;
    endcase
  end

  assign isBranch   = (heldOp == opB) | (heldOp == opBr);
  assign takeBranch = isBranch & condMet;

  // BR jumps to the register, B to the offset sum
  always_comb begin
    if (takeBranch) begin
      targetPc = (heldOp == opBr) ? rsData : branchTarget;
    end else begin
      targetPc = pcPlus2;
    end
  end

  ////////////////////
  // Handshake
  ////////////////////
  assign heldReady = pushReady;  // Stall only on a full queue
  assign pushValid = heldValid;
  assign pushPc    = targetPc;
  assign consume   = heldValid & pushReady;

  ////////////////////
  // State
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= `PC_RESET_ADDR;
    end else if (consume) begin
      pc <= targetPc;  // Same value goes into the queue
    end
  end

  // New flags apply from the next edge on
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= 3'b000;
    end else if (flagsWe) begin
      flags <= flagsIn;
    end
  end

endmodule

`default_nettype wire

//--- hw/instrIntake.sv
`timescale 1ns/1ps
`default_nettype none

module instrIntake (
  input  wire                 clk,
  input  wire                 rstN,
  // Instruction stream in
  input  wire                 instrValid,
  output logic                instrReady,
  input  var branchPkg::instrWord instr,
  // Held instruction out
  output logic                heldValid,
  input  wire                 heldReady,
  output branchPkg::opcode    heldOp,
  output branchPkg::condCode  heldCond,
  output logic [8:0]          heldOffset,
  output logic [3:0]          heldRsIdx
);

  import branchPkg::*;

  instrWord heldWord;  // Accepted instruction
  logic     full;      // Stage holds a word
  logic     accept;    // Word transfers this edge

  ////////////////////
  // Handshake
  ////////////////////

  // Ready when empty or when the held word leaves this cycle
  assign instrReady = ~full | heldReady;
  assign accept     = instrValid & instrReady;
  assign heldValid  = full;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      full <= 1'b0;
    end else if (instrReady) begin
      full <= instrValid;  // Refill, drain, or stay empty
    end
  end

  // Payload only, no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      heldWord <= instr;
    end
  end

  ////////////////////
  // Decode
  ////////////////////

  // Opcode and condition sit at the same bits in both views
  assign heldOp     = heldWord.b.op;
  assign heldCond   = heldWord.b.cond;

  assign heldOffset = heldWord.b.offset;  // B view
  assign heldRsIdx  = heldWord.br.rsIdx;  // BR view

endmodule

`default_nettype wire

//--- hw/cla16.sv
`timescale 1ns/1ps
`default_nettype none

module cla16 (
  input  wire [15:0] a,
  input  wire [15:0] b,
  output logic [15:0] sum
);

  logic [15:0] g;         // Bit generate
  logic [15:0] p;         // Bit propagate
  logic [3:0]  grpG;      // Group generate
  logic [3:0]  grpP;      // Group propagate
  logic [3:0]  grpCarry;  // Carry into each group

  assign g = a & b;
  assign p = a ^ b;

  ////////////////////
  // 4-bit groups
  ////////////////////
  for (genvar grp = 0; grp < 4; grp++) begin : gGroup
    logic [3:0] gg;
    logic [3:0] pp;
    logic [3:0] cc;  // Carry into each bit of the group

    assign gg = g[4*grp +: 4];
    assign pp = p[4*grp +: 4];

    // Lookahead inside the group
    assign cc[0] = grpCarry[grp];
    assign cc[1] = gg[0] | (pp[0] & cc[0]);
    assign cc[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cc[0]);
    assign cc[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                 | (pp[2] & pp[1] & pp[0] & cc[0]);

    // Group terms for the second level
    assign grpG[grp] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                     | (pp[3] & pp[2] & pp[1] & gg[0]);
    assign grpP[grp] = &pp;

    assign sum[4*grp +: 4] = pp ^ cc;
  end

  ////////////////////
  // Group lookahead
  ////////////////////
  // No carry in, carry out of group 3 is not needed
  assign grpCarry[0] = 1'b0;
  assign grpCarry[1] = grpG[0] | (grpP[0] & grpCarry[0]);
  assign grpCarry[2] = grpG[1] | (grpP[1] & grpG[0])
                     | (grpP[1] & grpP[0] & grpCarry[0]);
  assign grpCarry[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                     | (grpP[2] & grpP[1] & grpP[0] & grpCarry[0]);

endmodule

`default_nettype wire

//--- hw/branchPkg.sv
`default_nettype none

`include "branch_consts.svh"

package branchPkg;

  // Flags travel as a loose 3-bit vector
  // Bit 2 is Z, bit 1 is V, bit 0 is N

  ////////////////////
  // Condition codes
  ////////////////////
  typedef enum logic [2:0] {
    condNe = 3'd0,  // Z == 0
    condEq = 3'd1,  // Z == 1
    condGt = 3'd2,  // Z == 0 and N == 0
    condLt = 3'd3,  // N == 1
    condGe = 3'd4,  // Z == 1, or Z == N == 0
    condLe = 3'd5,  // Z == 1 or N == 1
    condOv = 3'd6,  // V == 1
    condAl = 3'd7   // Unconditional
  } condCode;

  // Only the two branch opcodes are named, all others advance by 2
  typedef enum logic [3:0] {
    opB  = `OPC_B,
    opBr = `OPC_BR
  } opcode;

  ////////////////////
  // Instruction views
  ////////////////////
  typedef struct packed {
    opcode             op;      // [15:12]
    condCode           cond;    // [11:9]
    logic signed [8:0] offset;  // [8:0] word offset
  } bFormat;

  typedef struct packed {
    opcode       op;     // [15:12]
    condCode     cond;   // [11:9]
    logic        pad0;   // [8]
    logic [3:0]  rsIdx;  // [7:4] target register
    logic [3:0]  pad1;   // [3:0]
  } brFormat;

  // Same 16 bits, read as B or as BR
  typedef union packed {
    bFormat  b;
    brFormat br;
  } instrWord;

endpackage

`default_nettype wire

//--- hw/branch_consts.svh
`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

////////////////////
// Reset and sizing
////////////////////

// PC after reset, first fetch address
`define PC_RESET_ADDR 16'h0000

// Default depth of the next-PC output queue
`define QUEUE_DEPTH 4

////////////////////
// Opcode values
////////////////////

`define OPC_B  4'hC  // Conditional branch, PC relative
`define OPC_BR 4'hD  // Conditional branch to register

`endif
